// File: verilog/retire_pkg.sv
package retire_pkg;

    // Data word shared by results, addresses and register contents
    typedef logic [31:0] word_t;

    // Byte write enables, one per byte lane of a word
    typedef logic [3:0] strobe_t;

    // Register index into the 32-entry integer register file
    typedef logic [4:0] reg_addr_t;

    // Memory operation kind carried with each instruction
    typedef enum logic [2:0] {
        OP_LB   = 3'd0,                         // Load byte, sign extended
        OP_LBU  = 3'd1,                         // Load byte, zero extended
        OP_LH   = 3'd2,                         // Load halfword, sign extended
        OP_LHU  = 3'd3,                         // Load halfword, zero extended
        OP_LW   = 3'd4,                         // Load full word
        OP_NONE = 3'd5                          // Stores and non-memory ops
    } instruction_type;

endpackage

// File: verilog/retire_control.sv
`timescale 1ns/1ps

module retire_control #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [TAG_WIDTH-1:0]  tag_in,        // Tag stamped at fetch
    input  logic                  jump,          // Jump request from execute
    input  logic                  we,            // Register write request
    input  retire_pkg::strobe_t   we_mem_in,     // Store byte enables
    input  logic                  exception,     // Exception request
    input  retire_pkg::word_t     result1,       // Jump target
    output logic [TAG_WIDTH-1:0]  curr_tag,      // Tag for new fetches
    output logic                  reg_we,        // Gated register write
    output logic                  jump_out,      // Gated jump to fetch
    output retire_pkg::word_t     new_pc,        // Redirect target
    output logic                  store_go,      // Gated store
    output logic                  exc_go         // Gated exception
);

    logic killed;                                // Wrong-path instruction

    assign killed = (tag_in != curr_tag);        // Any tag mismatch kills

    // Side effects survive only on the current path
    assign reg_we   = we & ~killed;
    assign jump_out = jump & ~killed;
    assign store_go = (we_mem_in != '0) & ~killed; // Any byte lane enabled
    assign exc_go   = exception & ~killed;

    always_comb begin
        if (jump_out) begin
            new_pc = result1;                    // Taken jump target
        end else begin
            new_pc = '0;                         // No redirect
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            curr_tag <= '0;
        end else if (jump_out) begin
            curr_tag <= curr_tag + 1'b1;         // Wraps at 2**TAG_WIDTH
        end
    end

endmodule

// File: verilog/writeback_format.sv
`timescale 1ns/1ps

module writeback_format (
    input  retire_pkg::instruction_type i,            // Load kind
    input  logic                        ls_operation, // Load in flight
    input  retire_pkg::word_t           data_in,      // Raw memory data
    input  retire_pkg::word_t           result0,      // ALU result
    output retire_pkg::word_t           wr_data       // Data to register bank
);

    retire_pkg::word_t mem_data;                 // Extended load data

    always_comb begin
        case (i)
            retire_pkg::OP_LB: begin
                mem_data = {{24{data_in[7]}}, data_in[7:0]};   // Sign fill
            end
            retire_pkg::OP_LBU: begin
                mem_data = {24'h000000, data_in[7:0]};
            end
            retire_pkg::OP_LH: begin
                mem_data = {{16{data_in[15]}}, data_in[15:0]}; // Sign fill
            end
            retire_pkg::OP_LHU: begin
                mem_data = {16'h0000, data_in[15:0]};
            end
            retire_pkg::OP_LW: begin
                mem_data = data_in;              // Full word as is
            end
            default: begin
                mem_data = '0;                   // OP_NONE and unused codes
            end
        endcase
    end

    // Loads take memory data, everything else the ALU result
    assign wr_data = ls_operation ? mem_data : result0;

endmodule

// File: verilog/store_port.sv
`timescale 1ns/1ps

module store_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                store_go,       // Surviving store this cycle
    input  retire_pkg::strobe_t we_mem_in,      // Byte enables from execute
    input  retire_pkg::word_t   result0,        // Store data
    input  retire_pkg::word_t   result1,        // Store address
    output retire_pkg::strobe_t write,          // Registered byte enables
    output retire_pkg::word_t   write_address,  // Registered address
    output retire_pkg::word_t   data_out        // Registered data
);

    // One-cycle pulse toward memory, zero when idle
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            write         <= '0;
            write_address <= '0;
            data_out      <= '0;
        end else if (store_go) begin
            write         <= we_mem_in;
            write_address <= result1;
            data_out      <= result0;
        end else begin
            write         <= '0;                 // Idle bus drives zero
            write_address <= '0;
            data_out      <= '0;
        end
    end

endmodule

// File: verilog/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reg_we,        // Gated write enable
    input  retire_pkg::reg_addr_t rd,            // Destination register
    input  retire_pkg::word_t     wr_data,       // Write-back value
    input  retire_pkg::reg_addr_t rs1_addr,      // First read port
    input  retire_pkg::reg_addr_t rs2_addr,      // Second read port
    output retire_pkg::word_t     rs1_data,
    output retire_pkg::word_t     rs2_data
);

    retire_pkg::word_t regs [NUM_REGS];          // Register storage
    logic              wr_ok;                    // Legal destination

    // x0 is never written, so reset keeps it at zero
    assign wr_ok = reg_we && (rd != '0) && (int'(rd) < NUM_REGS);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;                   // Whole file cleared
            end
        end else if (wr_ok) begin
            regs[rd] <= wr_data;                 // Visible next cycle
        end
    end

    // Combinational reads, out-of-range indices read zero
    always_comb begin
        if (int'(rs1_addr) < NUM_REGS) begin
            rs1_data = regs[rs1_addr];
        end else begin
            rs1_data = '0;
        end
    end

    always_comb begin
        if (int'(rs2_addr) < NUM_REGS) begin
            rs2_data = regs[rs2_addr];
        end else begin
            rs2_data = '0;
        end
    end

endmodule

// File: verilog/exception_log.sv
`timescale 1ns/1ps

module exception_log (
    input  logic              clk,
    input  logic              reset,
    input  logic              exc_go,           // Surviving exception
    input  retire_pkg::word_t npc,              // PC of the instruction
    input  retire_pkg::word_t instruction,      // Its encoding
    output logic              raise_exception,  // Sticky flag
    output retire_pkg::word_t exc_pc,           // First faulting PC
    output retire_pkg::word_t exc_instruction   // First faulting encoding
);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            raise_exception <= 1'b0;
            exc_pc          <= '0;
            exc_instruction <= '0;
        end else if (exc_go && !raise_exception) begin
            raise_exception <= 1'b1;             // Held until reset
            exc_pc          <= npc;
            exc_instruction <= instruction;
        end
        // Later exceptions leave the first capture in place
    end

endmodule

// File: verilog/retire_top.sv
`timescale 1ns/1ps

module retire_top #(
    parameter int TAG_WIDTH = 4,
    parameter int NUM_REGS  = 32
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        exception,       // Execute flagged a fault
    input  retire_pkg::word_t           instruction,     // Instruction encoding
    input  retire_pkg::word_t           npc,             // Instruction PC
    input  retire_pkg::word_t           result0,         // Write data, store data
    input  retire_pkg::word_t           result1,         // Jump target, store address
    input  logic                        jump,
    input  logic                        we,
    input  retire_pkg::reg_addr_t       rd,
    input  logic [TAG_WIDTH-1:0]        tag_in,
    input  retire_pkg::strobe_t         we_mem_in,
    input  retire_pkg::word_t           data_in,         // Load data from memory
    input  logic                        ls_operation,
    input  retire_pkg::instruction_type i,
    input  retire_pkg::reg_addr_t       rs1_addr,
    input  retire_pkg::reg_addr_t       rs2_addr,
    output logic                        jump_out,
    output retire_pkg::word_t           new_pc,
    output retire_pkg::word_t           write_address,
    output retire_pkg::word_t           data_out,
    output retire_pkg::strobe_t         write,
    output logic                        raise_exception,
    output retire_pkg::word_t           exc_pc,
    output retire_pkg::word_t           exc_instruction,
    output logic [TAG_WIDTH-1:0]        curr_tag,        // To fetch for stamping
    output retire_pkg::word_t           rs1_data,
    output retire_pkg::word_t           rs2_data
);

    logic              reg_we;                   // Gated register write
    logic              store_go;                 // Gated store
    logic              exc_go;                   // Gated exception
    retire_pkg::word_t wr_data;                  // Formatted write-back value

    retire_control #(
        .TAG_WIDTH (TAG_WIDTH)
    ) retire_control_i (
        .clk       (clk),
        .reset     (reset),
        .tag_in    (tag_in),
        .jump      (jump),
        .we        (we),
        .we_mem_in (we_mem_in),
        .exception (exception),
        .result1   (result1),
        .curr_tag  (curr_tag),
        .reg_we    (reg_we),
        .jump_out  (jump_out),
        .new_pc    (new_pc),
        .store_go  (store_go),
        .exc_go    (exc_go)
    );

    writeback_format writeback_format_i (
        .i            (i),
        .ls_operation (ls_operation),
        .data_in      (data_in),
        .result0      (result0),
        .wr_data      (wr_data)
    );

    store_port store_port_i (
        .clk           (clk),
        .reset         (reset),
        .store_go      (store_go),
        .we_mem_in     (we_mem_in),
        .result0       (result0),
        .result1       (result1),
        .write         (write),
        .write_address (write_address),
        .data_out      (data_out)
    );

    reg_bank #(
        .NUM_REGS (NUM_REGS)
    ) reg_bank_i (
        .clk      (clk),
        .reset    (reset),
        .reg_we   (reg_we),
        .rd       (rd),
        .wr_data  (wr_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exception_log exception_log_i (
        .clk             (clk),
        .reset           (reset),
        .exc_go          (exc_go),
        .npc             (npc),
        .instruction     (instruction),
        .raise_exception (raise_exception),
        .exc_pc          (exc_pc),
        .exc_instruction (exc_instruction)
    );

endmodule

// File: verif/retire_model.svh
`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

// Reference state of the retire stage, one update per retired instruction
logic [TAG_WIDTH-1:0] model_tag;                    // Expected curr_tag
retire_pkg::word_t    model_regs [NUM_REGS];        // Expected register contents
retire_pkg::strobe_t  model_write;                  // Store seen after the edge
retire_pkg::word_t    model_write_address;
retire_pkg::word_t    model_data_out;
logic                 model_exc;                    // Sticky exception flag
retire_pkg::word_t    model_exc_pc;
retire_pkg::word_t    model_exc_instruction;
logic                 model_jump_out;               // Same-cycle jump prediction
retire_pkg::word_t    model_new_pc;

// Load data as the register bank should see it
function automatic retire_pkg::word_t load_extend(
    input retire_pkg::instruction_type kind,
    input retire_pkg::word_t           raw
);
    byte     lo_byte;                                // Signed low byte
    shortint lo_half;                                // Signed low halfword
    lo_byte = raw[7:0];
    lo_half = raw[15:0];
    case (kind)
        retire_pkg::OP_LB:  return retire_pkg::word_t'(int'(lo_byte));
        retire_pkg::OP_LBU: return raw & 32'h0000_00ff;
        retire_pkg::OP_LH:  return retire_pkg::word_t'(int'(lo_half));
        retire_pkg::OP_LHU: return raw & 32'h0000_ffff;
        retire_pkg::OP_LW:  return raw;
        default:            return 32'h0000_0000;   // No load data
    endcase
endfunction

task automatic model_reset();
    model_tag             = '0;
    model_write           = '0;
    model_write_address   = '0;
    model_data_out        = '0;
    model_exc             = 1'b0;
    model_exc_pc          = '0;
    model_exc_instruction = '0;
    model_jump_out        = 1'b0;
    model_new_pc          = '0;
    for (int k = 0; k < NUM_REGS; k++) begin
        model_regs[k] = '0;                          // Whole file clear
    end
endtask

// Retires the instruction on the stimulus signals of this cycle
task automatic model_retire();
    logic killed;
    killed         = (tag_in != model_tag);          // Wrong path
    model_jump_out = jump && !killed;
    model_new_pc   = model_jump_out ? result1 : 32'h0000_0000;
    if (!killed && (we_mem_in != 4'h0)) begin
        model_write         = we_mem_in;
        model_write_address = result1;
        model_data_out      = result0;
    end else begin
        model_write         = '0;                    // Idle memory bus
        model_write_address = '0;
        model_data_out      = '0;
    end
    if (!killed && we && (rd != 5'd0)) begin
        model_regs[rd] = ls_operation ? load_extend(i, data_in) : result0;
    end
    if (!killed && exception && !model_exc) begin
        model_exc             = 1'b1;                // First one only
        model_exc_pc          = npc;
        model_exc_instruction = instruction;
    end
    if (model_jump_out) begin
        model_tag = model_tag + 1'b1;                // Wraps with the width
    end
endtask

`endif

// File: verif/retire_tb.sv
`timescale 1ns/1ps

module retire_tb;

    localparam int TAG_WIDTH    = 4;
    localparam int NUM_REGS     = 32;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 400;                // Random instructions
    localparam int DRIVE_DELAY  = 1;                  // After rising edge
    localparam int SAMPLE_DELAY = 2;                  // After driving
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS + 20) * CLK_PERIOD;

    logic                        clk;
    logic                        reset;
    logic                        exception;
    retire_pkg::word_t           instruction;
    retire_pkg::word_t           npc;
    retire_pkg::word_t           result0;
    retire_pkg::word_t           result1;
    logic                        jump;
    logic                        we;
    retire_pkg::reg_addr_t       rd;
    logic [TAG_WIDTH-1:0]        tag_in;
    retire_pkg::strobe_t         we_mem_in;
    retire_pkg::word_t           data_in;
    logic                        ls_operation;
    retire_pkg::instruction_type i;
    retire_pkg::reg_addr_t       rs1_addr;
    retire_pkg::reg_addr_t       rs2_addr;
    logic                        jump_out;
    retire_pkg::word_t           new_pc;
    retire_pkg::word_t           write_address;
    retire_pkg::word_t           data_out;
    retire_pkg::strobe_t         write;
    logic                        raise_exception;
    retire_pkg::word_t           exc_pc;
    retire_pkg::word_t           exc_instruction;
    logic [TAG_WIDTH-1:0]        curr_tag;
    retire_pkg::word_t           rs1_data;
    retire_pkg::word_t           rs2_data;

    logic [31:0] rng_state;                           // Xorshift state
    int          error_count;
    int          kills;                               // Stimulus statistics
    int          jumps;
    int          stores;

    `include "retire_model.svh"

    retire_top #(
        .TAG_WIDTH (TAG_WIDTH),
        .NUM_REGS  (NUM_REGS)
    ) retire_top_i (
        .clk             (clk),
        .reset           (reset),
        .exception       (exception),
        .instruction     (instruction),
        .npc             (npc),
        .result0         (result0),
        .result1         (result1),
        .jump            (jump),
        .we              (we),
        .rd              (rd),
        .tag_in          (tag_in),
        .we_mem_in       (we_mem_in),
        .data_in         (data_in),
        .ls_operation    (ls_operation),
        .i               (i),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .jump_out        (jump_out),
        .new_pc          (new_pc),
        .write_address   (write_address),
        .data_out        (data_out),
        .write           (write),
        .raise_exception (raise_exception),
        .exc_pc          (exc_pc),
        .exc_instruction (exc_instruction),
        .curr_tag        (curr_tag),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;        // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);            // Advances shared state
        return rng_state;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_word(input string what, input retire_pkg::word_t got,
                              input retire_pkg::word_t exp);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_strobe(input string what, input retire_pkg::strobe_t got,
                                input retire_pkg::strobe_t exp);
        if (got !== exp) begin
            report_mismatch(what, 32'(got), 32'(exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_mismatch(what, 32'(got), 32'(exp));
        end
    endtask

    task automatic check_tag(input string what, input logic [TAG_WIDTH-1:0] got,
                             input logic [TAG_WIDTH-1:0] exp);
        if (got !== exp) begin
            report_mismatch(what, 32'(got), 32'(exp));
        end
    endtask

    task automatic drive_idle();
        exception    = 1'b0;
        instruction  = '0;
        npc          = '0;
        result0      = '0;
        result1      = '0;
        jump         = 1'b0;
        we           = 1'b0;
        rd           = '0;
        tag_in       = '0;
        we_mem_in    = '0;
        data_in      = '0;
        ls_operation = 1'b0;
        i            = retire_pkg::OP_NONE;
        rs1_addr     = '0;
        rs2_addr     = '0;
    endtask

    // One random instruction, on the current path three times in four
    task automatic drive_random();
        logic [31:0]          r;
        logic [TAG_WIDTH-1:0] offset;
        r = next_random();
        if (r[1:0] != 2'b00) begin
            tag_in = model_tag;
        end else begin
            offset = r[TAG_WIDTH+1:2];
            if (offset == '0) begin
                offset = 1;                           // Force a mismatch
            end
            tag_in = model_tag ^ offset;
            kills++;
        end
        jump         = (r[8:6] < 3'd2);               // About one in four
        we           = r[9];
        rd           = r[14:10];
        we_mem_in    = r[15] ? r[19:16] : 4'h0;
        exception    = (r[23:20] == 4'h0);            // Rare faults
        ls_operation = r[24];
        i            = retire_pkg::instruction_type'(r[31:25] % 7'd6);
        result0      = next_random();
        result1      = next_random();
        data_in      = next_random();
        npc          = next_random() & 32'hffff_fffc; // Word aligned PC
        instruction  = next_random();
        r            = next_random();
        rs1_addr     = (r[2:0] == 3'd0) ? 5'd0 : r[7:3];   // x0 now and then
        rs2_addr     = (r[10:8] == 3'd0) ? 5'd0 : r[15:11];
    endtask

    task automatic check_reads();
        check_word("rs1_data", rs1_data, model_regs[rs1_addr]);
        check_word("rs2_data", rs2_data, model_regs[rs2_addr]);
        if (rs1_addr == 5'd0) begin
            check_word("rs1_data of x0", rs1_data, 32'h0000_0000);
        end
        if (rs2_addr == 5'd0) begin
            check_word("rs2_data of x0", rs2_data, 32'h0000_0000);
        end
    endtask

    task automatic check_registered();
        check_strobe("write", write, model_write);
        check_word("write_address", write_address, model_write_address);
        check_word("data_out", data_out, model_data_out);
        check_flag("raise_exception", raise_exception, model_exc);
        check_word("exc_pc", exc_pc, model_exc_pc);
        check_word("exc_instruction", exc_instruction, model_exc_instruction);
        check_tag("curr_tag", curr_tag, model_tag);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rng_state   = 32'h7ad0;                       // Fixed seed
        error_count = 0;
        kills       = 0;
        jumps       = 0;
        stores      = 0;
        reset       = 1'b0;                           // Asserted from time zero
        drive_idle();
        model_reset();

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            check_registered();                       // Cleared during reset
            check_reads();
        end
        reset = 1'b1;

        for (int n = 0; n < NUM_TESTS; n++) begin
            drive_random();
            #(SAMPLE_DELAY);
            check_reads();                            // Before this write lands
            model_retire();
            check_flag("jump_out", jump_out, model_jump_out);
            check_word("new_pc", new_pc, model_new_pc);
            if (model_jump_out) begin
                jumps++;
            end
            if (model_write != 4'h0) begin
                stores++;
            end
            @(posedge clk);
            #(DRIVE_DELAY);
            check_registered();                       // Effects of that edge
        end

        $display("Retired %0d instructions, %0d killed, %0d jumps, %0d stores",
                 NUM_TESTS, kills, jumps, stores);
        if (!model_exc || (kills == 0) || (jumps == 0) || (stores == 0)) begin
            $display("Random stimulus missed a kill, jump, store or exception");
            error_count++;
        end

        if (error_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "Stimulus did not reach every behavior");
        end
    end

endmodule

// File: build.f
+incdir+verif
verilog/retire_pkg.sv
verilog/retire_control.sv
verilog/writeback_format.sv
verilog/store_port.sv
verilog/reg_bank.sv
verilog/exception_log.sv
verilog/retire_top.sv
verif/retire_tb.sv
